/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
SEED      ?= 1
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f verilog.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f verilog.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)

/* logic/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetched pc after reset
// pre-fetch holds the word before it and issues the successor
`define RESET_PC 32'h1c000000

// requests accepted by memory but not yet answered
`define MAX_OUTSTANDING 2

`endif

/* logic/fetch_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend (
    input  logic                   clk,
    input  logic                   reset,
    // inst sram
    output logic                   inst_sram_req,
    output logic [31:0]            inst_sram_addr,
    input  logic                   inst_sram_addr_ok,
    input  logic                   inst_sram_data_ok,
    input  logic [31:0]            inst_sram_rdata,
    // redirects from later stages
    input  logic                   br_taken,
    input  logic [31:0]            br_target,
    input  logic                   wb_exc,
    input  logic [31:0]            exc_entry,
    input  logic                   wb_ertn,
    input  logic [31:0]            exc_retaddr,
    // to core
    input  logic                   out_ready,
    output logic                   out_valid,
    output logic [31:0]            out_pc,
    output logic [31:0]            out_inst,
    output fetch_pkg::inst_class_e out_class
);

    wire        flush;
    wire        fs_allowin;
    wire        pfs_to_fs_valid;
    wire [31:0] pfs_pc;
    wire        ds_allowin;
    wire        fs_to_ds_valid;
    wire [31:0] fs_pc;
    wire [31:0] fs_inst;

    // any redirect kills fs and ds contents
    assign flush = br_taken | wb_exc | wb_ertn;

    pre_if_stage pre_if_stage_i (
        .clk               (clk),
        .reset             (reset),
        .fs_allowin        (fs_allowin),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .wb_exc            (wb_exc),
        .exc_entry         (exc_entry),
        .wb_ertn           (wb_ertn),
        .exc_retaddr       (exc_retaddr),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .pfs_to_fs_valid   (pfs_to_fs_valid),
        .pfs_pc            (pfs_pc)
    );

    if_stage if_stage_i (
        .clk               (clk),
        .reset             (reset),
        .pfs_to_fs_valid   (pfs_to_fs_valid),
        .pfs_pc            (pfs_pc),
        .flush             (flush),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .ds_allowin        (ds_allowin),
        .fs_allowin        (fs_allowin),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_pc             (fs_pc),
        .fs_inst           (fs_inst)
    );

    predecode_stage predecode_stage_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .out_ready      (out_ready),
        .ds_allowin     (ds_allowin),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_inst       (out_inst),
        .out_class      (out_class)
    );

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // source of a latched redirect in pre-fetch
    typedef enum logic [1:0] {
        none,
        branch,
        exc,
        ertn
    } redirect_kind_e;

    // fetch stage state
    typedef enum logic [1:0] {
        idle,
        wait_data,
        hold
    } if_state_e;

    // coarse opcode class from predecode
    typedef enum logic [2:0] {
        cls_alu,
        cls_branch,
        cls_jump,
        cls_load,
        cls_store
    } inst_class_e;

endpackage

`default_nettype wire

/* logic/if_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module if_stage (
    input  logic        clk,
    input  logic        reset,
    // from pfs
    input  logic        pfs_to_fs_valid,
    input  logic [31:0] pfs_pc,
    input  logic        flush,
    // inst sram response
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata,
    // to / from ds
    input  logic        ds_allowin,
    output logic        fs_allowin,
    output logic        fs_to_ds_valid,
    output logic [31:0] fs_pc,
    output logic [31:0] fs_inst
);

    localparam int unsigned       cnt_wd  = $clog2(`MAX_OUTSTANDING + 1);
    localparam logic [cnt_wd-1:0] max_cnt = cnt_wd'(`MAX_OUTSTANDING);

    fetch_pkg::if_state_e state;

    logic [cnt_wd-1:0] discard_cnt;
    logic [cnt_wd-1:0] owed;
    logic [cnt_wd-1:0] discard_next;

    logic        waiting;
    logic        data_stale;
    logic        data_live;
    logic        slot_free;
    logic        fs_fire;
    logic [31:0] inst_buf;

    assign waiting = (state == fetch_pkg::wait_data);

    // responses still to come, cancelled ones first
    assign owed = discard_cnt + cnt_wd'(waiting);

    assign data_stale = inst_sram_data_ok && (discard_cnt != '0);
    assign data_live  = inst_sram_data_ok && (discard_cnt == '0) && waiting;

    // on flush everything still owed turns into discards
    assign discard_next = flush ? owed - cnt_wd'(inst_sram_data_ok)
                                : discard_cnt - cnt_wd'(data_stale);

    always_comb begin
        if (flush) begin
            slot_free = 1'b1;
        end else begin
            case (state)
                fetch_pkg::idle: begin
                    slot_free = 1'b1;
                end
                fetch_pkg::wait_data: begin
                    slot_free = data_live && ds_allowin;
                end
                default: begin
                    slot_free = ds_allowin;
                end
            endcase
        end
    end

    // no new request while the memory queue is full of dead answers
    assign fs_allowin = slot_free && (discard_next < max_cnt);
    assign fs_fire    = pfs_to_fs_valid && fs_allowin;

    assign fs_to_ds_valid = !flush && (data_live || (state == fetch_pkg::hold));
    assign fs_inst        = (state == fetch_pkg::hold) ? inst_buf : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= fetch_pkg::idle;
            discard_cnt <= '0;
        end else begin
            discard_cnt <= discard_next;
            if (fs_fire) begin
                state <= fetch_pkg::wait_data;
            end else if (flush) begin
                state <= fetch_pkg::idle;
            end else begin
                case (state)
                    fetch_pkg::wait_data: begin
                        if (data_live) begin
                            state <= ds_allowin ? fetch_pkg::idle : fetch_pkg::hold;
                        end
                    end
                    fetch_pkg::hold: begin
                        if (ds_allowin) begin
                            state <= fetch_pkg::idle;
                        end
                    end
                    default: begin
                        state <= fetch_pkg::idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fs_fire) begin
            fs_pc <= pfs_pc;
        end
    end

    // park the word while ds is full
    always_ff @(posedge clk) begin
        if (data_live && !ds_allowin) begin
            inst_buf <= inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

/* logic/pre_if_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module pre_if_stage (
    input  logic        clk,
    input  logic        reset,
    // from fs
    input  logic        fs_allowin,
    // redirects
    input  logic        br_taken,
    input  logic [31:0] br_target,
    input  logic        wb_exc,
    input  logic [31:0] exc_entry,
    input  logic        wb_ertn,
    input  logic [31:0] exc_retaddr,
    // inst sram
    output logic        inst_sram_req,
    output logic [31:0] inst_sram_addr,
    input  logic        inst_sram_addr_ok,
    // to fs
    output logic        pfs_to_fs_valid,
    output logic [31:0] pfs_pc
);

    logic        pfs_valid;
    logic        pfs_ready_go;
    logic        pfs_fire;

    logic [31:0] pc_r;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;

    fetch_pkg::redirect_kind_e pulse_kind;
    logic [31:0]               pulse_target;
    fetch_pkg::redirect_kind_e redir_kind_r;
    logic [31:0]               redir_target_r;

    // same-cycle redirect, exc over ertn over branch
    always_comb begin
        if (wb_exc) begin
            pulse_kind   = fetch_pkg::exc;
            pulse_target = exc_entry;
        end else if (wb_ertn) begin
            pulse_kind   = fetch_pkg::ertn;
            pulse_target = exc_retaddr;
        end else if (br_taken) begin
            pulse_kind   = fetch_pkg::branch;
            pulse_target = br_target;
        end else begin
            pulse_kind   = fetch_pkg::none;
            pulse_target = br_target;
        end
    end

    // a fresh pulse beats an older latched one
    assign seq_pc = pc_r + 32'd4;
    assign nextpc = (pulse_kind != fetch_pkg::none)   ? pulse_target   :
                    (redir_kind_r != fetch_pkg::none) ? redir_target_r :
                                                        seq_pc;

    assign pfs_ready_go    = inst_sram_req && inst_sram_addr_ok;
    assign pfs_to_fs_valid = pfs_valid && pfs_ready_go;
    assign pfs_fire        = pfs_to_fs_valid && fs_allowin;
    assign pfs_pc          = nextpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pfs_valid <= 1'b0;
        end else begin
            pfs_valid <= 1'b1;
        end
    end

    // request only when fs has room for the answer.
    // the address moves under a pending request only in a redirect cycle
    assign inst_sram_req  = pfs_valid && fs_allowin;
    assign inst_sram_addr = nextpc;

    // keep the redirect until its target request is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            redir_kind_r <= fetch_pkg::none;
        end else if (pfs_fire) begin
            redir_kind_r <= fetch_pkg::none;
        end else if (pulse_kind != fetch_pkg::none) begin
            redir_kind_r <= pulse_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (pulse_kind != fetch_pkg::none) begin
            redir_target_r <= pulse_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_r <= `RESET_PC - 32'd4;
        end else if (pfs_fire) begin
            pc_r <= nextpc;
        end
    end

endmodule

`default_nettype wire

/* logic/predecode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module predecode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    // from fs
    input  logic                   fs_to_ds_valid,
    input  logic [31:0]            fs_pc,
    input  logic [31:0]            fs_inst,
    // to core
    input  logic                   out_ready,
    output logic                   ds_allowin,
    output logic                   out_valid,
    output logic [31:0]            out_pc,
    output logic [31:0]            out_inst,
    output fetch_pkg::inst_class_e out_class
);

    logic                   ds_valid;
    logic                   ds_fire;
    fetch_pkg::inst_class_e inst_class;

    // opcode field is bits 31:26
    function automatic fetch_pkg::inst_class_e classify(input logic [31:0] inst);
        case (inst[31:26])
            6'h14, 6'h15: begin
                classify = fetch_pkg::cls_jump;
            end
            6'h13, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                classify = fetch_pkg::cls_branch;
            end
            6'h0a: begin
                // bit 24 splits loads from stores
                classify = inst[24] ? fetch_pkg::cls_store : fetch_pkg::cls_load;
            end
            default: begin
                classify = fetch_pkg::cls_alu;
            end
        endcase
    endfunction

    assign inst_class = classify(fs_inst);
    assign ds_allowin = !ds_valid || out_ready;
    assign ds_fire    = fs_to_ds_valid && ds_allowin;
    assign out_valid  = ds_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // output register holds while the core stalls
    always_ff @(posedge clk) begin
        if (ds_fire) begin
            out_pc    <= fs_pc;
            out_inst  <= fs_inst;
            out_class <= inst_class;
        end
    end

endmodule

`default_nettype wire

/* tests/fetch_frontend_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   inst_sram_req,
    input logic [31:0]            inst_sram_addr,
    input logic                   inst_sram_addr_ok,
    input logic                   redirect,
    input logic                   out_valid,
    input logic                   out_ready,
    input logic [31:0]            out_pc,
    input logic [31:0]            out_inst,
    input fetch_pkg::inst_class_e out_class
);

    // failed assertion count
    int unsigned fail_count = 0;

    // pending request keeps its address unless a redirect moves it
    addr_hold_a: assert property (@(posedge clk) disable iff (reset)
        inst_sram_req && !inst_sram_addr_ok |=>
            !inst_sram_req || redirect || $stable(inst_sram_addr))
        else begin
            fail_count++;
            $error("inst_sram_addr changed while a request was pending");
        end

    // stalled output register
    out_hold_a: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect |=>
            out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_class))
        else begin
            fail_count++;
            $error("output changed or dropped while out_ready was low");
        end

    reset_idle_a: assert property (@(posedge clk)
        reset |=> !inst_sram_req && !out_valid)
        else begin
            fail_count++;
            $error("request or output active right after reset");
        end

endmodule

bind fetch_frontend fetch_frontend_chk chk_i (
    .clk               (clk),
    .reset             (reset),
    .inst_sram_req     (inst_sram_req),
    .inst_sram_addr    (inst_sram_addr),
    .inst_sram_addr_ok (inst_sram_addr_ok),
    .redirect          (flush),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_pc            (out_pc),
    .out_inst          (out_inst),
    .out_class         (out_class)
);

`default_nettype wire

/* tests/fetch_frontend_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_frontend_tb;

    typedef struct packed {
        logic [7:0]                n_before;
        fetch_pkg::redirect_kind_e first;
        logic                      with_branch;
        fetch_pkg::redirect_kind_e second;
        logic [31:0]               target;
        logic [7:0]                stall;
    } row_t;

    localparam int n_rows = 7;

    // outputs accepted before the event, then redirects and out_ready pattern
    // zero pattern means random out_ready
    localparam row_t rows [n_rows] = '{
        '{8'd64, fetch_pkg::branch, 1'b0, fetch_pkg::none,   32'h1c000400, 8'hff},
        '{8'd12, fetch_pkg::exc,    1'b1, fetch_pkg::none,   32'h18000000, 8'hb5},
        '{8'd12, fetch_pkg::ertn,   1'b1, fetch_pkg::none,   32'h1c008000, 8'h6e},
        '{8'd6,  fetch_pkg::branch, 1'b0, fetch_pkg::exc,    32'h1c010000, 8'h93},
        '{8'd7,  fetch_pkg::exc,    1'b0, fetch_pkg::ertn,   32'h18020000, 8'h00},
        '{8'd20, fetch_pkg::branch, 1'b0, fetch_pkg::branch, 32'h1c030000, 8'h00},
        '{8'd16, fetch_pkg::none,   1'b0, fetch_pkg::none,   32'h00000000, 8'h00}
    };
    string names [n_rows] = '{"seq_then_branch", "exc_over_branch", "ertn_over_branch",
                              "branch_then_exc", "exc_then_ertn", "branch_twice",
                              "random_stall_drain"};

    logic                   clk;
    logic                   reset;
    logic                   inst_sram_req;
    logic [31:0]            inst_sram_addr;
    logic                   inst_sram_addr_ok;
    logic                   inst_sram_data_ok;
    logic [31:0]            inst_sram_rdata;
    logic                   br_taken;
    logic [31:0]            br_target;
    logic                   wb_exc;
    logic [31:0]            exc_entry;
    logic                   wb_ertn;
    logic [31:0]            exc_retaddr;
    logic                   out_ready;
    logic                   out_valid;
    logic [31:0]            out_pc;
    logic [31:0]            out_inst;
    fetch_pkg::inst_class_e out_class;

    integer      seed = 32'hb036;
    int unsigned accepted;
    int          cur_row;
    logic [31:0] expected_pc;
    logic [31:0] expected_inst;

    fetch_frontend dut_i (.*);

    inst_sram_model mem_i (
        .clk     (clk),
        .reset   (reset),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    function automatic logic [31:0] model_word(input logic [31:0] pc);
        return {pc[7:2], pc[27:2] ^ 26'h2b036};
    endfunction

    function automatic fetch_pkg::inst_class_e expected_class(input logic [31:0] word);
        logic [5:0] op;
        op = word[31:26];
        if (op == 6'h14 || op == 6'h15) begin
            return fetch_pkg::cls_jump;
        end else if (op == 6'h13 || (op >= 6'h16 && op <= 6'h1b)) begin
            return fetch_pkg::cls_branch;
        end else if (op == 6'h0a) begin
            return word[24] ? fetch_pkg::cls_store : fetch_pkg::cls_load;
        end
        return fetch_pkg::cls_alu;
    endfunction

    function automatic logic ready_bit(input logic [7:0] pattern, input logic [2:0] k);
        if (pattern == 8'h00) begin
            return ($random(seed) & 1) == 1;
        end
        return pattern[k];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic drive_redirect(input fetch_pkg::redirect_kind_e kind,
                                  input logic with_branch, input logic [31:0] base);
        br_taken    <= with_branch || (kind == fetch_pkg::branch);
        wb_exc      <= (kind == fetch_pkg::exc);
        wb_ertn     <= (kind == fetch_pkg::ertn);
        br_target   <= base;
        exc_entry   <= base + 32'h1000;
        exc_retaddr <= base + 32'h2000;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // expected stream, restarted by the winning redirect
    always @(posedge clk) begin
        if (reset) begin
            expected_pc = `RESET_PC;
            accepted <= 0;
        end else if (wb_exc || wb_ertn || br_taken) begin
            expected_pc = wb_exc ? exc_entry : (wb_ertn ? exc_retaddr : br_target);
        end else if (out_valid && out_ready) begin
            expected_inst = model_word(expected_pc);
            compare_value({names[cur_row], " pc"}, expected_pc, out_pc);
            compare_value({names[cur_row], " inst"}, expected_inst, out_inst);
            compare_value({names[cur_row], " class"}, 32'(expected_class(expected_inst)),
                          32'(out_class));
            expected_pc = expected_pc + 32'd4;
            accepted <= accepted + 1;
        end
    end

    // bound protocol assertions count their failures
    always @(posedge clk) begin
        if (dut_i.chk_i.fail_count != 0) begin
            $display("protocol assertion failed during %s", names[cur_row]);
            $display("ERRORS FOUND");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        int unsigned total;
        total = 0;
        for (int i = 0; i < n_rows; i++) begin
            total = total + 32'(rows[i].n_before);
        end
        repeat (total * 40) @(posedge clk);
        $display("front end stuck, no progress within %0d cycles", total * 40);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int unsigned goal;
        logic [2:0]  k;
        reset       = 1'b1;
        out_ready   = 1'b0;
        br_taken    = 1'b0;
        br_target   = '0;
        wb_exc      = 1'b0;
        exc_entry   = '0;
        wb_ertn     = 1'b0;
        exc_retaddr = '0;
        cur_row     = 0;
        goal        = 0;
        k           = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            goal = goal + 32'(rows[r].n_before);
            cur_row <= r;
            @(posedge clk);
            while (accepted + ((out_valid && out_ready) ? 1 : 0) < goal) begin
                out_ready <= ready_bit(rows[r].stall, k);
                k = k + 3'd1;
                @(posedge clk);
            end
            // core stalled so nothing transfers in a redirect cycle
            out_ready <= 1'b0;
            if (rows[r].first != fetch_pkg::none) begin
                drive_redirect(rows[r].first, rows[r].with_branch, rows[r].target);
                @(posedge clk);
                drive_redirect(rows[r].second, 1'b0, rows[r].target + 32'h40);
                @(posedge clk);
                drive_redirect(fetch_pkg::none, 1'b0, '0);
            end
        end
        @(negedge clk);
        if (dut_i.chk_i.fail_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "protocol assertion failed at end of run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/inst_sram_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module inst_sram_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    integer      seed = 32'hb036;
    logic        addr_ok_r = 1'b0;
    logic        data_ok_r = 1'b0;
    logic [31:0] rdata_r = '0;
    logic [31:0] head;
    logic [31:0] pending [$];

    assign addr_ok = addr_ok_r;
    assign data_ok = data_ok_r;
    assign rdata   = rdata_r;

    always @(posedge clk) begin
        if (reset) begin
            pending.delete();
            addr_ok_r <= 1'b0;
            data_ok_r <= 1'b0;
        end else begin
            // oldest request answers first, never in its own accept cycle
            data_ok_r <= 1'b0;
            if (pending.size() != 0 && ($random(seed) & 1) == 1) begin
                head = pending.pop_front();
                data_ok_r <= 1'b1;
                rdata_r   <= {head[7:2], head[27:2] ^ 26'h2b036};
            end
            if (req && addr_ok_r) begin
                pending.push_back(addr);
            end
            addr_ok_r <= (pending.size() < `MAX_OUTSTANDING) && (($random(seed) & 3) != 0);
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/fetch_pkg.sv
logic/pre_if_stage.sv
logic/if_stage.sv
logic/predecode_stage.sv
logic/fetch_frontend.sv
tests/inst_sram_model.sv
tests/fetch_frontend_chk.sv
tests/fetch_frontend_tb.sv
